//--- vga_pkg.sv
package vga_pkg;

    ////////////////////////////////
    // 800x480 timing, negative sync
    ////////////////////////////////
    localparam int H_ACTIVE     = 800;
    localparam int H_SYNC_START = 824;   // 24 clocks front porch
    localparam int H_SYNC_END   = 896;   // 72 clocks of hsync
    localparam int H_TOTAL      = 992;
    localparam int V_ACTIVE     = 480;
    localparam int V_SYNC_START = 483;   // 3 lines front porch
    localparam int V_SYNC_END   = 490;   // 7 lines of vsync
    localparam int V_TOTAL      = 500;

    ////////////////////////////////
    // framebuffer geometry
    ////////////////////////////////
    localparam int FB_WIDTH       = 200;
    localparam int FB_HEIGHT      = 120;
    localparam int FB_SCALE_SHIFT = 2;                      // 4x4 screen pixels per entry
    localparam int FB_DEPTH       = FB_WIDTH * FB_HEIGHT;   // 24000

    typedef logic [9:0]  coord_t;        // screen x or y
    typedef logic [14:0] fb_addr_t;      // one bank, row major
    typedef logic [3:0]  color_index_t;
    typedef logic [3:0]  channel_t;

    typedef struct packed {
        channel_t red;
        channel_t green;
        channel_t blue;
    } rgb_t;

    // red ramps up, green ramps down, blue follows red
    localparam rgb_t PALETTE [16] = '{
        '{4'h0, 4'hf, 4'h0},
        '{4'h1, 4'he, 4'h1},
        '{4'h2, 4'hd, 4'h2},
        '{4'h3, 4'hc, 4'h3},
        '{4'h4, 4'hb, 4'h4},
        '{4'h5, 4'ha, 4'h5},
        '{4'h6, 4'h9, 4'h6},
        '{4'h7, 4'h8, 4'h7},
        '{4'h8, 4'h7, 4'h8},
        '{4'h9, 4'h6, 4'h9},
        '{4'ha, 4'h5, 4'ha},
        '{4'hb, 4'h4, 4'hb},
        '{4'hc, 4'h3, 4'hc},
        '{4'hd, 4'h2, 4'hd},
        '{4'he, 4'h1, 4'he},
        '{4'hf, 4'h0, 4'hf}
    };

endpackage

//--- scan_if.sv
`timescale 1ns/1ps

// one scan position per clock, all fields of the same cycle
interface scan_if;

    vga_pkg::coord_t sx;   // horizontal position
    vga_pkg::coord_t sy;   // vertical position
    logic hsync;           // active low
    logic vsync;           // active low
    logic de;              // inside 800x480
    logic frame_end;       // last pixel of the frame

    modport source (output sx, sy, hsync, vsync, de, frame_end);
    modport sink   (input  sx, sy, hsync, vsync, de, frame_end);

endinterface

//--- display_timing.sv
`timescale 1ns/1ps

module display_timing (
    input logic    clk_pix,
    input logic    rst_pix,
    scan_if.source scan
);

    vga_pkg::coord_t x_nxt;
    vga_pkg::coord_t y_nxt;
    logic            line_last;

    //////////////////////////////
    // next position
    //////////////////////////////
    always_comb begin
        line_last = (scan.sx == vga_pkg::coord_t'(vga_pkg::H_TOTAL - 1));
        x_nxt     = line_last ? '0 : scan.sx + 1'b1;
        y_nxt     = scan.sy;
        if (line_last) begin
            // wrap the line counter at the bottom of the frame
            if (scan.sy == vga_pkg::coord_t'(vga_pkg::V_TOTAL - 1)) begin
                y_nxt = '0;
            end else begin
                y_nxt = scan.sy + 1'b1;
            end
        end
    end

    //////////////////////////////
    // registered scan position
    //////////////////////////////
    // flags are decoded from the next position so they line up with sx/sy
    always_ff @(posedge clk_pix) begin
        if (rst_pix) begin
            scan.sx        <= '0;
            scan.sy        <= '0;
            scan.hsync     <= 1'b1;   // inactive
            scan.vsync     <= 1'b1;
            scan.de        <= 1'b1;   // 0,0 is an active pixel
            scan.frame_end <= 1'b0;
        end else begin
            scan.sx    <= x_nxt;
            scan.sy    <= y_nxt;
            scan.hsync <= ~(x_nxt >= vga_pkg::H_SYNC_START && x_nxt < vga_pkg::H_SYNC_END);
            scan.vsync <= ~(y_nxt >= vga_pkg::V_SYNC_START && y_nxt < vga_pkg::V_SYNC_END);
            scan.de    <= (x_nxt < vga_pkg::H_ACTIVE) && (y_nxt < vga_pkg::V_ACTIVE);
            scan.frame_end <= (x_nxt == vga_pkg::coord_t'(vga_pkg::H_TOTAL - 1)) &&
                              (y_nxt == vga_pkg::coord_t'(vga_pkg::V_TOTAL - 1));
        end
    end

    // position never leaves the frame
    a_pos_in_frame: assert property (@(posedge clk_pix) disable iff (rst_pix)
        scan.sx < vga_pkg::H_TOTAL && scan.sy < vga_pkg::V_TOTAL)
        else $error("scan position outside frame");

endmodule

//--- fb_bank.sv
`timescale 1ns/1ps

// one bank of color indices, simple dual port
module fb_bank (
    input  logic                  clk_pix,
    input  logic                  wr_en,
    input  vga_pkg::fb_addr_t     wr_addr,
    input  vga_pkg::color_index_t wr_index,
    input  vga_pkg::fb_addr_t     rd_addr,
    output vga_pkg::color_index_t rd_index
);

    vga_pkg::color_index_t mem [vga_pkg::FB_DEPTH];

    // write port
    always_ff @(posedge clk_pix) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_index;
        end
    end

    // read port, one clock latency
    always_ff @(posedge clk_pix) begin
        rd_index <= mem[rd_addr];
    end

endmodule

//--- frame_buffer_pair.sv
`timescale 1ns/1ps

module frame_buffer_pair (
    input  logic                  clk_pix,
    input  logic                  rst_pix,
    input  logic                  frame_end,
    input  logic                  wr_en,
    input  logic                  swap_req,
    input  vga_pkg::fb_addr_t     wr_addr,
    input  vga_pkg::color_index_t wr_index,
    input  vga_pkg::fb_addr_t     rd_addr,
    output vga_pkg::color_index_t rd_index,
    output logic                  swap_pending
);

    logic                  front_sel;     // 0: bank0 is shown
    logic                  front_sel_d;   // matches the read latency
    vga_pkg::color_index_t bank0_index;
    vga_pkg::color_index_t bank1_index;

    //////////////////////////////
    // swap control
    //////////////////////////////
    always_ff @(posedge clk_pix) begin
        if (rst_pix) begin
            front_sel    <= 1'b0;
            front_sel_d  <= 1'b0;
            swap_pending <= 1'b0;
        end else begin
            front_sel_d  <= front_sel;
            swap_pending <= swap_req || (swap_pending && !frame_end);
            if (frame_end && swap_pending) begin
                front_sel <= ~front_sel;   // flip on last pixel of frame
            end
        end
    end

    // both banks see the scan address, writes go to the back bank only
    fb_bank bank0 (
        .clk_pix  (clk_pix),
        .wr_en    (wr_en && front_sel),
        .wr_addr  (wr_addr),
        .wr_index (wr_index),
        .rd_addr  (rd_addr),
        .rd_index (bank0_index)
    );

    fb_bank bank1 (
        .clk_pix  (clk_pix),
        .wr_en    (wr_en && !front_sel),
        .wr_addr  (wr_addr),
        .wr_index (wr_index),
        .rd_addr  (rd_addr),
        .rd_index (bank1_index)
    );

    assign rd_index = front_sel_d ? bank1_index : bank0_index;

    a_wr_in_range: assert property (@(posedge clk_pix) disable iff (rst_pix)
        wr_en |-> wr_addr < vga_pkg::FB_DEPTH)
        else $error("write address %0d out of range", wr_addr);

endmodule

//--- pixel_scanout.sv
`timescale 1ns/1ps

module pixel_scanout (
    input  logic                  clk_pix,
    input  logic                  rst_pix,
    scan_if.sink                  scan,
    output vga_pkg::fb_addr_t     rd_addr,
    input  vga_pkg::color_index_t rd_index,
    output logic                  vga_hsync,
    output logic                  vga_vsync,
    output vga_pkg::channel_t     vga_r,
    output vga_pkg::channel_t     vga_g,
    output vga_pkg::channel_t     vga_b
);

    vga_pkg::fb_addr_t fb_x;   // screen x / 4
    vga_pkg::fb_addr_t fb_y;   // screen y / 4
    logic              hsync_d;
    logic              vsync_d;
    logic              de_d;
    vga_pkg::rgb_t     color;

    //////////////////////////////
    // address generation
    //////////////////////////////
    always_comb begin
        fb_x    = vga_pkg::fb_addr_t'(scan.sx >> vga_pkg::FB_SCALE_SHIFT);
        fb_y    = vga_pkg::fb_addr_t'(scan.sy >> vga_pkg::FB_SCALE_SHIFT);
        rd_addr = vga_pkg::fb_addr_t'(fb_y * vga_pkg::FB_WIDTH + fb_x);   // row major
    end

    // stage 1: syncs wait for the bank read
    always_ff @(posedge clk_pix) begin
        if (rst_pix) begin
            hsync_d <= 1'b1;
            vsync_d <= 1'b1;
            de_d    <= 1'b0;
        end else begin
            hsync_d <= scan.hsync;
            vsync_d <= scan.vsync;
            de_d    <= scan.de;
        end
    end

    // palette lookup, black in blanking
    assign color = de_d ? vga_pkg::PALETTE[rd_index] : '0;

    //////////////////////////////
    // stage 2: output register
    //////////////////////////////
    always_ff @(posedge clk_pix) begin
        if (rst_pix) begin
            vga_hsync <= 1'b1;
            vga_vsync <= 1'b1;
            {vga_r, vga_g, vga_b} <= '0;
        end else begin
            vga_hsync <= hsync_d;
            vga_vsync <= vsync_d;
            {vga_r, vga_g, vga_b} <= color;
        end
    end

    a_rd_in_range: assert property (@(posedge clk_pix) disable iff (rst_pix)
        scan.de |-> rd_addr < vga_pkg::FB_DEPTH)
        else $error("active pixel maps outside framebuffer");

endmodule

//--- vga_top.sv
`timescale 1ns/1ps

module vga_top (
    input  logic                  clk_pix,
    input  logic                  rst_pix,
    input  logic                  wr_en,
    input  logic                  swap_req,
    input  vga_pkg::fb_addr_t     wr_addr,
    input  vga_pkg::color_index_t wr_index,
    output logic                  swap_pending,
    output logic                  vga_hsync,
    output logic                  vga_vsync,
    output vga_pkg::channel_t     vga_r,
    output vga_pkg::channel_t     vga_g,
    output vga_pkg::channel_t     vga_b
);

    vga_pkg::fb_addr_t     rd_addr;    // scanout to buffers
    vga_pkg::color_index_t rd_index;   // front bank data

    scan_if scan0 ();

    // producer
    display_timing timing0 (
        .clk_pix (clk_pix),
        .rst_pix (rst_pix),
        .scan    (scan0.source)
    );

    // buffer
    frame_buffer_pair fb_pair0 (
        .clk_pix      (clk_pix),
        .rst_pix      (rst_pix),
        .frame_end    (scan0.frame_end),
        .wr_en        (wr_en),
        .swap_req     (swap_req),
        .wr_addr      (wr_addr),
        .wr_index     (wr_index),
        .rd_addr      (rd_addr),
        .rd_index     (rd_index),
        .swap_pending (swap_pending)
    );

    // consumer
    pixel_scanout scanout0 (
        .clk_pix   (clk_pix),
        .rst_pix   (rst_pix),
        .scan      (scan0.sink),
        .rd_addr   (rd_addr),
        .rd_index  (rd_index),
        .vga_hsync (vga_hsync),
        .vga_vsync (vga_vsync),
        .vga_r     (vga_r),
        .vga_g     (vga_g),
        .vga_b     (vga_b)
    );

endmodule

//--- tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// expected color of one output pixel, black outside 800x480
function automatic vga_pkg::rgb_t ref_color(
    input int x,
    input int y,
    const ref vga_pkg::color_index_t bank [vga_pkg::FB_DEPTH]
);
    int            addr;
    vga_pkg::rgb_t rgb;
    rgb = '0;
    if (x < vga_pkg::H_ACTIVE && y < vga_pkg::V_ACTIVE) begin
        // each entry covers a 4x4 block of screen pixels
        addr = (y >> vga_pkg::FB_SCALE_SHIFT) * vga_pkg::FB_WIDTH + (x >> vga_pkg::FB_SCALE_SHIFT);
        rgb  = vga_pkg::PALETTE[bank[addr]];
    end
    return rgb;
endfunction

task automatic color_check(input string name, input vga_pkg::rgb_t exp, input vga_pkg::rgb_t act);
    if (act !== exp) begin
        $display("Mismatch %s at x=%0d y=%0d: expected %h, got %h", name, ox, oy, exp, act);
        stop_on_error();
    end
endtask

task automatic sync_check(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        $display("Mismatch %s at x=%0d y=%0d: expected %h, got %h", name, ox, oy, exp, act);
        stop_on_error();
    end
endtask

task automatic pending_check(input logic exp, input logic act);
    if (act !== exp) begin
        $display("Mismatch swap_pending: expected %h, got %h", exp, act);
        stop_on_error();
    end
endtask

`endif

//--- tb_vga_top.sv
`timescale 1ns/1ps

module tb_vga_top;

    localparam logic [31:0] LFSR_SEED = 32'he68;
    localparam int TIMEOUT_CYCLES = 3_000_000;   // ~5 frames of 496000 plus two bank fills

    logic                  clk_pix;
    logic                  rst_pix;
    logic                  wr_en;
    logic                  swap_req;
    vga_pkg::fb_addr_t     wr_addr;
    vga_pkg::color_index_t wr_index;
    logic                  swap_pending;
    logic                  vga_hsync;
    logic                  vga_vsync;
    vga_pkg::channel_t     vga_r;
    vga_pkg::channel_t     vga_g;
    vga_pkg::channel_t     vga_b;

    vga_pkg::color_index_t model0 [vga_pkg::FB_DEPTH];   // bank0 contents
    vga_pkg::color_index_t model1 [vga_pkg::FB_DEPTH];   // bank1 contents
    logic                  valid0;                       // bank holds a known pattern
    logic                  valid1;
    logic [31:0]           lfsr_state;
    int                    cycle_cnt;

    // output position, locked from the sync edges
    int            ox;
    int            oy;
    logic          x_locked;
    logic          y_locked;
    logic          hs_prev;
    logic          vs_prev;
    int            frame_cnt;
    logic          exp_pending;
    logic          scan_front;    // front bank as seen by the scan side
    logic          out_front;     // front bank of the frame on the outputs
    logic          fe_now;
    logic          shown_valid;
    vga_pkg::rgb_t exp_rgb;

    vga_top dut0 (
        .clk_pix      (clk_pix),
        .rst_pix      (rst_pix),
        .wr_en        (wr_en),
        .swap_req     (swap_req),
        .wr_addr      (wr_addr),
        .wr_index     (wr_index),
        .swap_pending (swap_pending),
        .vga_hsync    (vga_hsync),
        .vga_vsync    (vga_vsync),
        .vga_r        (vga_r),
        .vga_g        (vga_g),
        .vga_b        (vga_b)
    );

    task automatic stop_on_error();
        $display("Test FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    `include "tb_checks.svh"

    // x^32 + x^22 + x^2 + x + 1, new bit enters at bit 0
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    ////////////////////////////////
    // stimulus helpers
    ////////////////////////////////
    task automatic fill_back_bank();
        int                    a;
        logic                  back;
        vga_pkg::color_index_t idx;
        back = ~scan_front;
        idx  = '0;
        for (a = 0; a < vga_pkg::FB_DEPTH; a++) begin
            repeat (4) begin   // one lfsr step per bit
                lfsr_state = lfsr_step(lfsr_state);
                idx        = {idx[2:0], lfsr_state[0]};
            end
            @(posedge clk_pix);
            wr_en    <= 1'b1;
            wr_addr  <= vga_pkg::fb_addr_t'(a);
            wr_index <= idx;
            if (back) model1[a] = idx;
            else model0[a] = idx;
        end
        @(posedge clk_pix);
        wr_en <= 1'b0;
        if (back) valid1 = 1'b1;
        else valid0 = 1'b1;
    endtask

    // one cycle pulse, then wait for the swap at the frame end
    task automatic request_swap();
        @(posedge clk_pix);
        swap_req <= 1'b1;
        @(posedge clk_pix);
        swap_req <= 1'b0;
        @(negedge clk_pix);
        while (swap_pending) @(negedge clk_pix);
    endtask

    task automatic until_line(input int line);
        while (!(y_locked && oy == line)) @(posedge clk_pix);
    endtask

    task automatic skip_frames(input int n);
        int target;
        target = frame_cnt + n;
        while (frame_cnt < target) @(posedge clk_pix);
    endtask

    always #10 clk_pix = ~clk_pix;

    always @(posedge clk_pix) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            stop_on_error();
        end
    end

    ////////////////////////////////
    // output checker, samples mid cycle
    ////////////////////////////////
    always @(negedge clk_pix) begin
        if (!rst_pix) begin
            if (x_locked) begin
                ox = (ox == vga_pkg::H_TOTAL - 1) ? 0 : ox + 1;
                if (ox == 0 && y_locked) oy = (oy == vga_pkg::V_TOTAL - 1) ? 0 : oy + 1;
            end
            if (!x_locked && hs_prev && !vga_hsync) begin
                ox       = vga_pkg::H_SYNC_START;   // hsync falls at x 824
                x_locked = 1'b1;
            end
            if (x_locked && !y_locked && vs_prev && !vga_vsync) begin
                oy       = vga_pkg::V_SYNC_START;   // vsync falls at the start of line 483
                y_locked = 1'b1;
            end
            hs_prev = vga_hsync;
            vs_prev = vga_vsync;
            pending_check(exp_pending, swap_pending);
            fe_now = 1'b0;
            if (y_locked) begin
                if (ox == 0 && oy == 0) begin
                    out_front = scan_front;   // new frame on the outputs
                    frame_cnt = frame_cnt + 1;
                end
                sync_check("vga_hsync", !(ox >= vga_pkg::H_SYNC_START &&
                           ox < vga_pkg::H_SYNC_END), vga_hsync);
                sync_check("vga_vsync", !(oy >= vga_pkg::V_SYNC_START &&
                           oy < vga_pkg::V_SYNC_END), vga_vsync);
                shown_valid = out_front ? valid1 : valid0;
                if (out_front) exp_rgb = ref_color(ox, oy, model1);
                else exp_rgb = ref_color(ox, oy, model0);
                if (shown_valid || ox >= vga_pkg::H_ACTIVE || oy >= vga_pkg::V_ACTIVE) begin
                    color_check("vga_rgb", exp_rgb, {vga_r, vga_g, vga_b});
                end
                // scan runs two pixels ahead of the outputs
                fe_now = (ox == vga_pkg::H_TOTAL - 3) && (oy == vga_pkg::V_TOTAL - 1);
                if (fe_now && exp_pending) scan_front = ~scan_front;
            end
            exp_pending = swap_req || (exp_pending && !fe_now);
        end
    end

    initial begin
        clk_pix     = 1'b0;
        rst_pix     = 1'b1;
        wr_en       = 1'b0;
        swap_req    = 1'b0;
        wr_addr     = '0;
        wr_index    = '0;
        valid0      = 1'b0;
        valid1      = 1'b0;
        lfsr_state  = LFSR_SEED;
        cycle_cnt   = 0;
        ox          = 0;
        oy          = 0;
        x_locked    = 1'b0;
        y_locked    = 1'b0;
        hs_prev     = 1'b1;
        vs_prev     = 1'b1;
        frame_cnt   = 0;
        exp_pending = 1'b0;
        scan_front  = 1'b0;
        out_front   = 1'b0;
        repeat (9) @(posedge clk_pix);
        @(negedge clk_pix);
        sync_check("vga_hsync", 1'b1, vga_hsync);   // outputs idle in reset
        sync_check("vga_vsync", 1'b1, vga_vsync);
        color_check("vga_rgb", '0, {vga_r, vga_g, vga_b});
        pending_check(1'b0, swap_pending);
        @(posedge clk_pix);
        rst_pix <= 1'b0;

        while (!y_locked) @(posedge clk_pix);
        fill_back_bank();   // pattern A into bank1
        request_swap();
        fill_back_bank();   // pattern B into bank0 while A is shown
        until_line(240);
        request_swap();     // mid frame, takes effect at the end
        skip_frames(3);     // B shown twice, second frame without a request
        $display("Test OK");
        $finish;
    end

endmodule

//--- files.f
+incdir+.
vga_pkg.sv
scan_if.sv
display_timing.sv
fb_bank.sv
frame_buffer_pair.sv
pixel_scanout.sv
vga_top.sv
tb_vga_top.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -j 0 --top-module tb_vga_top \
		-Mdir obj_dir -f files.f
	./obj_dir/Vtb_vga_top

clean:
	rm -rf obj_dir
